// ==== hdl/core_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared constants for the RV32I execution shell: word and index
// widths, opcode and function fields, ALU operation type and the
// instruction word union
//////////////////////////////////////////////////////////////////////

`default_nettype none

package core_pkg;

  // Data word and register index widths
  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 5;

  // Major opcodes
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;

  // funct3 groups
  localparam logic [2:0] funct3_add = 3'b000;
  localparam logic [2:0] funct3_sll = 3'b001;
  localparam logic [2:0] funct3_slt = 3'b010;
  localparam logic [2:0] funct3_xor = 3'b100;
  localparam logic [2:0] funct3_srl = 3'b101;
  localparam logic [2:0] funct3_or  = 3'b110;
  localparam logic [2:0] funct3_and = 3'b111;

  // funct7 value that turns ADD into SUB
  localparam logic [6:0] funct7_sub = 7'b0100000;

  typedef enum logic [3:0] {
    add,
    sub,
    and_op,
    or_op,
    xor_op,
    slt,
    sll,
    srl
  } alu_op_e;

  // One instruction word, read as R-type or I-type depending on opcode
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm12;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } i;
  } instr_u;

endpackage

`default_nettype wire

// ==== hdl/stage_if.sv ====
//////////////////////////////////////////////////////////////////////
// Stage interfaces: decode to execute, execute to write-back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

interface decode_if import core_pkg::*; ();
  logic                  valid;
  logic                  illegal;
  alu_op_e               alu_op;
  logic [xlen-1:0]       operand_a;
  logic [xlen-1:0]       operand_b;
  logic [reg_addr_w-1:0] rd;

  modport src (output valid, illegal, alu_op, operand_a, operand_b, rd);
  modport dst (input valid, illegal, alu_op, operand_a, operand_b, rd);
endinterface

interface exec_if import core_pkg::*; ();
  logic                  valid;
  logic                  illegal;
  logic [xlen-1:0]       result;
  logic [reg_addr_w-1:0] rd;

  modport src (output valid, illegal, result, rd);
  modport dst (input valid, illegal, result, rd);
endinterface

`default_nettype wire

// ==== hdl/register_file.sv ====
//////////////////////////////////////////////////////////////////////
// Integer register file: 31 flip-flop words, x0 hardwired to zero,
// two combinational read ports and one write port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module register_file import core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [reg_addr_w-1:0] raddr_a_i,
  input  logic [reg_addr_w-1:0] raddr_b_i,
  output logic [xlen-1:0]       rdata_a_o,
  output logic [xlen-1:0]       rdata_b_o,
  input  logic [reg_addr_w-1:0] waddr_i,
  input  logic [xlen-1:0]       wdata_i,
  input  logic                  we_i
);

  logic [xlen-1:0] regs_q [1:31];

  // Writes to index zero fall through the loop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < 32; i++) begin
        if (we_i && waddr_i == reg_addr_w'(i)) begin
          regs_q[i] <= wdata_i;
        end
      end
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== hdl/instr_decode.sv ====
//////////////////////////////////////////////////////////////////////
// Instruction decode stage: classifies the accepted word, reads the
// register file and registers the operands for execute
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module instr_decode import core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  instr_u                instr_i,
  output logic [reg_addr_w-1:0] rf_raddr_a_o,
  output logic [reg_addr_w-1:0] rf_raddr_b_o,
  input  logic [xlen-1:0]       rf_rdata_a_i,
  input  logic [xlen-1:0]       rf_rdata_b_i,
  decode_if.src                 dec
);

  alu_op_e         alu_op_d;
  logic            illegal_d;
  logic            use_imm;
  logic [xlen-1:0] imm_ext;

  // rs2 field overlaps the immediate on I-type, reading it is harmless
  assign rf_raddr_a_o = instr_i.r.rs1;
  assign rf_raddr_b_o = instr_i.r.rs2;

  assign imm_ext = {{(xlen-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};

  always_comb begin
    alu_op_d  = add;
    illegal_d = 1'b0;
    use_imm   = 1'b0;
    case (instr_i.r.opcode)
      opcode_op: begin
        case (instr_i.r.funct3)
          funct3_add: alu_op_d = (instr_i.r.funct7 == funct7_sub) ? sub : add;
          funct3_slt: alu_op_d = slt;
          funct3_sll: alu_op_d = sll;
          funct3_xor: alu_op_d = xor_op;
          funct3_srl: alu_op_d = srl;
          funct3_or:  alu_op_d = or_op;
          funct3_and: alu_op_d = and_op;
          default:    illegal_d = 1'b1;
        endcase
        // Only ADD accepts a nonzero funct7
        if (instr_i.r.funct7 != 7'b0 &&
            !(instr_i.r.funct3 == funct3_add && instr_i.r.funct7 == funct7_sub)) begin
          illegal_d = 1'b1;
        end
      end
      opcode_op_imm: begin
        use_imm = 1'b1;
        case (instr_i.i.funct3)
          funct3_add: alu_op_d = add;
          funct3_slt: alu_op_d = slt;
          funct3_xor: alu_op_d = xor_op;
          funct3_or:  alu_op_d = or_op;
          funct3_and: alu_op_d = and_op;
          // Immediate shifts are not supported
          default:    illegal_d = 1'b1;
        endcase
      end
      default: illegal_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= start_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      dec.illegal   <= illegal_d;
      dec.alu_op    <= alu_op_d;
      dec.operand_a <= rf_rdata_a_i;
      dec.operand_b <= use_imm ? imm_ext : rf_rdata_b_i;
      dec.rd        <= instr_i.r.rd;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/alu_execute.sv ====
//////////////////////////////////////////////////////////////////////
// Integer ALU stage with registered result
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module alu_execute import core_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  decode_if.dst dec,
  exec_if.src   exe
);

  logic [xlen-1:0] alu_result;
  logic [4:0]      shamt;

  // Shift amount from the low bits only
  assign shamt = dec.operand_b[4:0];

  always_comb begin
    case (dec.alu_op)
      add:     alu_result = dec.operand_a + dec.operand_b;
      sub:     alu_result = dec.operand_a - dec.operand_b;
      and_op:  alu_result = dec.operand_a & dec.operand_b;
      or_op:   alu_result = dec.operand_a | dec.operand_b;
      xor_op:  alu_result = dec.operand_a ^ dec.operand_b;
      slt: begin
        alu_result = {{(xlen-1){1'b0}},
                      ($signed(dec.operand_a) < $signed(dec.operand_b))};
      end
      sll:     alu_result = dec.operand_a << shamt;
      srl:     alu_result = dec.operand_a >> shamt;
      default: alu_result = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exe.valid <= 1'b0;
    end else begin
      exe.valid <= dec.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec.valid) begin
      exe.illegal <= dec.illegal;
      exe.rd      <= dec.rd;
      // Illegal items carry a zero result
      exe.result  <= dec.illegal ? '0 : alu_result;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/writeback_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Handshake controller: start pulse, register write-back, result
// outputs and sleep indication
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module writeback_ctrl import core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  instr_req_i,
  output logic                  start_o,
  exec_if.dst                   exe,
  output logic                  rf_we_o,
  output logic [reg_addr_w-1:0] rf_waddr_o,
  output logic [xlen-1:0]       rf_wdata_o,
  output logic                  instr_ack_o,
  output logic [xlen-1:0]       result_o,
  output logic [reg_addr_w-1:0] rd_o,
  output logic                  illegal_o,
  output logic                  core_sleep_o
);

  logic start_d, start_q;
  logic busy_q;
  logic ack_q;

  // New work only when idle and no acknowledge is standing
  assign start_d = instr_req_i & ~busy_q & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
      busy_q  <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      start_q <= start_d;
      if (start_d) begin
        busy_q <= 1'b1;
      end else if (exe.valid) begin
        busy_q <= 1'b0;
      end
      if (exe.valid) begin
        ack_q <= 1'b1;
      end else if (!instr_req_i) begin
        ack_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result outputs, held while acknowledged
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_o  <= '0;
      rd_o      <= '0;
      illegal_o <= 1'b0;
    end else if (exe.valid) begin
      result_o  <= exe.result;
      rd_o      <= exe.rd;
      illegal_o <= exe.illegal;
    end else if (ack_q && !instr_req_i) begin
      // Cleared together with the falling acknowledge
      result_o  <= '0;
      rd_o      <= '0;
      illegal_o <= 1'b0;
    end
  end

  // Write-back on the same edge as the acknowledge
  assign rf_we_o    = exe.valid & ~exe.illegal;
  assign rf_waddr_o = exe.rd;
  assign rf_wdata_o = exe.result;

  assign start_o      = start_q;
  assign instr_ack_o  = ack_q;
  assign core_sleep_o = ~(busy_q | ack_q);

endmodule

`default_nettype wire

// ==== hdl/core_top.sv ====
//////////////////////////////////////////////////////////////////////
// RV32I execution shell top level: decode, execute, write-back
// controller and integer register file
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module core_top import core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  instr_req_i,
  input  logic [xlen-1:0]       instr_i,
  output logic                  instr_ack_o,
  output logic [xlen-1:0]       result_o,
  output logic [reg_addr_w-1:0] rd_o,
  output logic                  illegal_o,
  output logic                  core_sleep_o
);

  logic                  start;
  logic [reg_addr_w-1:0] rf_raddr_a;
  logic [reg_addr_w-1:0] rf_raddr_b;
  logic [xlen-1:0]       rf_rdata_a;
  logic [xlen-1:0]       rf_rdata_b;
  logic                  rf_we;
  logic [reg_addr_w-1:0] rf_waddr;
  logic [xlen-1:0]       rf_wdata;

  decode_if dec_bus ();
  exec_if   exe_bus ();

  instr_decode u_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .instr_i      (instr_i),
    .rf_raddr_a_o (rf_raddr_a),
    .rf_raddr_b_o (rf_raddr_b),
    .rf_rdata_a_i (rf_rdata_a),
    .rf_rdata_b_i (rf_rdata_b),
    .dec          (dec_bus.src)
  );

  alu_execute u_execute (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .dec    (dec_bus.dst),
    .exe    (exe_bus.src)
  );

  register_file u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we)
  );

  writeback_ctrl u_writeback (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .instr_req_i  (instr_req_i),
    .start_o      (start),
    .exe          (exe_bus.dst),
    .rf_we_o      (rf_we),
    .rf_waddr_o   (rf_waddr),
    .rf_wdata_o   (rf_wdata),
    .instr_ack_o  (instr_ack_o),
    .result_o     (result_o),
    .rd_o         (rd_o),
    .illegal_o    (illegal_o),
    .core_sleep_o (core_sleep_o)
  );

endmodule

`default_nettype wire

// ==== test/core_properties.sv ====
//////////////////////////////////////////////////////////////////////
// Concurrent assertions on the handshake, write-back and sleep
// indication, bound into the write-back controller
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module core_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic instr_req_i,
  input logic instr_ack_i,
  input logic rf_we_i,
  input logic illegal_i,
  input logic core_sleep_i
);

  int failures;

  initial failures = 0;

  ack_needs_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(instr_ack_i) |-> $past(instr_req_i))
    else begin
      failures++;
      $error("acknowledge rose without a pending request");
    end

  // Ack drops on the edge that sees the request low
  ack_follows_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (!instr_req_i && instr_ack_i) |=> !instr_ack_i)
    else begin
      failures++;
      $error("acknowledge stayed high after the request fell");
    end

  // The item written back is the one now shown on the outputs
  no_illegal_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rf_we_i |=> !illegal_i)
    else begin
      failures++;
      $error("register write for an item flagged illegal");
    end

  // Sleep stays low over the whole flight up to the acknowledge
  awake_while_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(instr_ack_i) |-> !core_sleep_i && !$past(core_sleep_i) &&
                             !$past(core_sleep_i, 2) && !$past(core_sleep_i, 3))
    else begin
      failures++;
      $error("core_sleep_o high while an instruction was in flight");
    end

endmodule

bind writeback_ctrl core_properties props_i (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .instr_req_i  (instr_req_i),
  .instr_ack_i  (instr_ack_o),
  .rf_we_i      (rf_we_o),
  .illegal_i    (illegal_o),
  .core_sleep_i (core_sleep_o)
);

`default_nettype wire

// ==== test/core_checker.sv ====
//////////////////////////////////////////////////////////////////////
// Result checker: compares the DUT outputs on each acknowledge,
// checks the acknowledge latency and the sleep indication
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module core_checker (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        instr_req_i,
  input logic        instr_ack_i,
  input logic [31:0] result_i,
  input logic [4:0]  rd_i,
  input logic        illegal_i,
  input logic        core_sleep_i
);

  string       exp_name;
  logic [31:0] exp_result;
  logic [4:0]  exp_rd;
  logic        exp_illegal;
  logic        armed;
  logic        ack_prev;
  int          req_edges;
  int          pass_count;
  int          fail_count;
  int          error_count;

  initial begin
    armed       = 1'b0;
    ack_prev    = 1'b0;
    req_edges   = 0;
    pass_count  = 0;
    fail_count  = 0;
    error_count = 0;
  end

  task automatic load_expected(input string name, input logic [31:0] result,
                               input logic [4:0] rd, input logic illegal);
    exp_name    = name;
    exp_result  = result;
    exp_rd      = rd;
    exp_illegal = illegal;
    armed       = 1'b1;
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    error_count++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sampled just before each rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_prev  = 1'b0;
      req_edges = 0;
    end else begin
      if ((req_edges > 0 || instr_ack_i) && core_sleep_i) begin
        report_problem("core_sleep_o is high while an instruction is in flight");
      end
      if (req_edges == 0 && !instr_ack_i && !instr_req_i && !core_sleep_i) begin
        report_problem("core_sleep_o is low while the core is idle");
      end
      if (req_edges == 0 && !instr_ack_i && (result_i != 0 || rd_i != 0 || illegal_i)) begin
        report_problem("result outputs are not cleared while no acknowledge stands");
      end
      // Ack rose on the previous edge
      if (instr_ack_i && !ack_prev) begin
        if (req_edges != 4) begin
          report_problem($sformatf("%s: acknowledge came %0d edges after the request, not 4",
                                   exp_name, req_edges));
        end
        if (!armed) begin
          report_problem("acknowledge rose with no instruction expected");
        end else if (result_i !== exp_result || rd_i !== exp_rd ||
                     illegal_i !== exp_illegal) begin
          $display(
            "ERROR %s: expected result=%h rd=%0d illegal=%0b, actual result=%h rd=%0d illegal=%0b",
            exp_name, exp_result, exp_rd, exp_illegal, result_i, rd_i, illegal_i);
          fail_count++;
        end else begin
          $display("PASS  %s: result=%h rd=%0d illegal=%0b", exp_name, result_i, rd_i,
                   illegal_i);
          pass_count++;
        end
        armed     = 1'b0;
        req_edges = 0;
      end
      if (instr_req_i && !instr_ack_i) begin
        req_edges++;
      end
      ack_prev = instr_ack_i;
    end
  end

endmodule

`default_nettype wire

// ==== test/core_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the RV32I execution shell: clock, reset, stimulus
// table, req/ack driving loop, watchdog and final report
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module core_tb;

  logic        clk;
  logic        rst_n;
  logic        instr_req;
  logic [31:0] instr;
  logic        instr_ack;
  logic [31:0] result;
  logic [4:0]  rd;
  logic        illegal;
  logic        core_sleep;

  string       test_name[$];
  logic [31:0] test_word[$];
  logic [31:0] test_result[$];
  logic [4:0]  test_rd[$];
  logic        test_illegal[$];

  // Expected register contents while the table is built
  logic [31:0] model_rf [0:31];
  integer      seed;
  logic        table_ready;

  core_top dut_i (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .instr_req_i  (instr_req),
    .instr_i      (instr),
    .instr_ack_o  (instr_ack),
    .result_o     (result),
    .rd_o         (rd),
    .illegal_o    (illegal),
    .core_sleep_o (core_sleep)
  );

  core_checker chk_i (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .instr_req_i  (instr_req),
    .instr_ack_i  (instr_ack),
    .result_i     (result),
    .rd_i         (rd),
    .illegal_i    (illegal),
    .core_sleep_i (core_sleep)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] r_type_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] funct3,
                                              input logic [4:0] dst);
    return {funct7, rs2, rs1, funct3, dst, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] funct3, input logic [4:0] dst);
    return {imm, rs1, funct3, dst, 7'b0010011};
  endfunction

  function automatic logic [31:0] sign_extend12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] less_signed(input logic [31:0] a, input logic [31:0] b);
    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
  endfunction

  task automatic add_test(input string name, input logic [31:0] word,
                          input logic [31:0] exp_result, input logic exp_illegal);
    test_name.push_back(name);
    test_word.push_back(word);
    test_result.push_back(exp_result);
    test_rd.push_back(word[11:7]);
    test_illegal.push_back(exp_illegal);
    if (!exp_illegal && word[11:7] != 5'd0) begin
      model_rf[word[11:7]] = exp_result;
    end
  endtask

  task automatic build_table();
    logic [11:0] imm_a, imm_b, imm_c, imm_d, imm_e, imm_f, imm_g, imm_sh;
    int          i;
    for (i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    seed   = 71;
    imm_a  = $random(seed);
    imm_b  = $random(seed);
    imm_c  = $random(seed);
    imm_d  = $random(seed);
    imm_e  = $random(seed);
    imm_f  = $random(seed);
    imm_g  = $random(seed);
    imm_sh = $random(seed);
    // Positive nonzero x1, negative x2, shift amount with high bits set
    imm_a  = (imm_a & 12'h7ff) | 12'h010;
    imm_b  = imm_b | 12'h800;
    imm_sh = imm_sh | 12'hfe0;

    add_test("addi_x1", i_type_word(imm_a, 5'd0, 3'b000, 5'd1), sign_extend12(imm_a), 1'b0);
    add_test("addi_x2_neg", i_type_word(imm_b, 5'd0, 3'b000, 5'd2), sign_extend12(imm_b), 1'b0);
    add_test("ori_x3", i_type_word(imm_c, 5'd0, 3'b110, 5'd3), sign_extend12(imm_c), 1'b0);
    add_test("xori_x4", i_type_word(imm_d, 5'd0, 3'b100, 5'd4), sign_extend12(imm_d), 1'b0);
    add_test("andi_x5", i_type_word(imm_e, 5'd0, 3'b111, 5'd5), 32'd0, 1'b0);
    add_test("slti_x6", i_type_word(imm_f, 5'd0, 3'b010, 5'd6),
             less_signed(32'd0, sign_extend12(imm_f)), 1'b0);
    add_test("addi_x15", i_type_word(imm_sh, 5'd0, 3'b000, 5'd15), sign_extend12(imm_sh), 1'b0);
    add_test("add_x7", r_type_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd7),
             model_rf[1] + model_rf[2], 1'b0);
    add_test("sub_borrow", r_type_word(7'h20, 5'd1, 5'd5, 3'b000, 5'd8),
             model_rf[5] - model_rf[1], 1'b0);
    add_test("and_x9", r_type_word(7'h00, 5'd4, 5'd2, 3'b111, 5'd9),
             model_rf[2] & model_rf[4], 1'b0);
    add_test("or_x10", r_type_word(7'h00, 5'd3, 5'd1, 3'b110, 5'd10),
             model_rf[1] | model_rf[3], 1'b0);
    add_test("xor_x11", r_type_word(7'h00, 5'd3, 5'd2, 3'b100, 5'd11),
             model_rf[2] ^ model_rf[3], 1'b0);
    add_test("slt_neg", r_type_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd12),
             less_signed(model_rf[2], model_rf[1]), 1'b0);
    add_test("slt_pos", r_type_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd13),
             less_signed(model_rf[1], model_rf[2]), 1'b0);
    add_test("sll_5bit", r_type_word(7'h00, 5'd15, 5'd1, 3'b001, 5'd14),
             model_rf[1] << model_rf[15][4:0], 1'b0);
    add_test("srl_5bit", r_type_word(7'h00, 5'd15, 5'd2, 3'b101, 5'd16),
             model_rf[2] >> model_rf[15][4:0], 1'b0);
    add_test("addi_rd_x0", i_type_word(imm_g, 5'd1, 3'b000, 5'd0),
             model_rf[1] + sign_extend12(imm_g), 1'b0);
    add_test("add_src_x0", r_type_word(7'h00, 5'd4, 5'd0, 3'b000, 5'd17), model_rf[4], 1'b0);
    // LUI opcode is outside the supported set
    add_test("illegal_opcode", {imm_c, 5'd3, 3'b000, 5'd1, 7'b0110111}, 32'd0, 1'b1);
    add_test("read_after_opcode", r_type_word(7'h00, 5'd0, 5'd1, 3'b000, 5'd18),
             model_rf[1], 1'b0);
    add_test("illegal_funct7", r_type_word(7'h01, 5'd3, 5'd1, 3'b000, 5'd2), 32'd0, 1'b1);
    add_test("read_after_funct7", r_type_word(7'h00, 5'd0, 5'd2, 3'b000, 5'd19),
             model_rf[2], 1'b0);
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic run_test(input int idx);
    chk_i.load_expected(test_name[idx], test_result[idx], test_rd[idx], test_illegal[idx]);
    instr     = test_word[idx];
    instr_req = 1'b1;
    @(negedge clk);
    while (!instr_ack) @(negedge clk);
    instr_req = 1'b0;
    @(negedge clk);
    while (instr_ack) @(negedge clk);
    instr = '0;
    repeat (2) @(negedge clk);
  endtask

  initial begin : main_flow
    int idx;
    int other_errors;
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_req   = 1'b0;
    instr       = '0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    for (idx = 0; idx < test_name.size(); idx++) begin
      run_test(idx);
    end
    repeat (3) @(negedge clk);
    other_errors = chk_i.error_count + dut_i.u_writeback.props_i.failures;
    $display("Summary: %0d passed, %0d failed, %0d other errors", chk_i.pass_count,
             chk_i.fail_count, other_errors);
    if (chk_i.fail_count == 0 && other_errors == 0 && chk_i.pass_count == test_name.size()) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // 20 cycles per table entry on top of the reset time
  initial begin : watchdog
    int limit_cycles;
    wait (table_ready === 1'b1);
    limit_cycles = 8 + 20 * test_name.size();
    #(limit_cycles * 10);
    $display("Run timed out after %0d cycles before all tests finished", limit_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/core_pkg.sv
hdl/stage_if.sv
hdl/register_file.sv
hdl/instr_decode.sv
hdl/alu_execute.sv
hdl/writeback_ctrl.sv
hdl/core_top.sv
test/core_properties.sv
test/core_checker.sv
test/core_tb.sv
